// File: verilog.f
+incdir+logic
logic/cache_pkg.sv
logic/bram.sv
logic/cache.sv
logic/burst_ram.sv
logic/cache_subsystem.sv
bench/cache_checker.sv
bench/tb_cache.sv

// File: run_sim.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_cache -o tb_cache
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_cache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: bench/tb_cache.sv
//########################################
// testbench for the cache subsystem
// applies a table of fixed and random requests through
// the enable / busy port, cache_checker does the comparing
//########################################
`timescale 1ns/10ps
`include "cache_consts.svh"

module tb_cache;

  localparam int clk_period = 100;
  localparam int reset_cycles = 10;
  localparam int fixed_count = 11;
  localparam int rand_count = 40;
  localparam int num_entries = fixed_count + rand_count;
  // the idle check after the tag sweep is a test of its own
  localparam int num_tests = num_entries + 1;
  localparam int line_count = 2 ** `CACHE_LINE_IX_BITS;
  // dirty miss: write burst, interval, read burst, fill and tag update
  localparam int miss_cycles = 2 * (`CACHE_CMD_INTERVAL + 1) + `CACHE_BURST_LATENCY +
                               2 * `CACHE_BURST_BEATS + 4;
  localparam int limit_cycles = reset_cycles + line_count + num_entries * miss_cycles * 2;

  typedef struct packed {
    logic [127:0] name;
    logic write;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0] mask;
    logic has_exp;
    logic [31:0] exp_data;
  } stim_t;

  logic clk;
  logic rst_n;
  logic enable;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [3:0] write_enable;
  logic [31:0] data_out;
  logic data_out_ready;
  logic busy;
  logic [127:0] test_name;
  logic check_idle;
  logic exp_valid;
  logic [31:0] exp_data;
  int pass_count;
  int fail_count;
  logic [31:0] lfsr;
  stim_t stim [num_entries];

  cache_subsystem u_dut (
    .clk,
    .rst_n,
    .enable,
    .address,
    .data_in,
    .write_enable,
    .data_out,
    .data_out_ready,
    .busy
  );

  cache_checker u_checker (
    .clk,
    .rst_n,
    .enable,
    .address,
    .data_in,
    .write_enable,
    .data_out,
    .data_out_ready,
    .busy,
    .test_name,
    .check_idle,
    .exp_valid,
    .exp_data,
    .pass_count,
    .fail_count
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // a few line indices that both tags collide on
  function automatic logic [7:0] pick_line(input logic [1:0] sel);
    case (sel)
      2'd0: return 8'h03;
      2'd1: return 8'h04;
      2'd2: return 8'h83;
      default: return 8'hfc;
    endcase
  endfunction

  function automatic stim_t make_entry(input logic [127:0] name, input logic write,
                                       input logic [31:0] addr, input logic [31:0] data,
                                       input logic [3:0] mask, input logic has_exp,
                                       input logic [31:0] exp_word);
    stim_t s;
    s.name = name;
    s.write = write;
    s.addr = addr;
    s.data = data;
    s.mask = mask;
    s.has_exp = has_exp;
    s.exp_data = exp_word;
    return s;
  endfunction

  task automatic build_table();
    logic [31:0] bits;
    logic wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0] mask;
    // write misses into a clean line, then hits
    stim[0] = make_entry("wr_fill", 1'b1, 32'h0000_0120, 32'ha5a5_1234, 4'hf, 1'b0, '0);
    stim[1] = make_entry("rd_hit", 1'b0, 32'h0000_0120, '0, 4'h0, 1'b1, 32'ha5a5_1234);
    // byte lanes of one word
    stim[2] = make_entry("wr_word", 1'b1, 32'h0000_0124, 32'h1111_1111, 4'hf, 1'b0, '0);
    stim[3] = make_entry("wr_lane1", 1'b1, 32'h0000_0124, 32'h0000_2200, 4'b0010, 1'b0, '0);
    stim[4] = make_entry("wr_lane3", 1'b1, 32'h0000_0124, 32'h4400_0000, 4'b1000, 1'b0, '0);
    stim[5] = make_entry("rd_merge", 1'b0, 32'h0000_0124, '0, 4'h0, 1'b1, 32'h4411_2211);
    // tag 1 on the same line pushes the dirty tag 0 line out
    stim[6] = make_entry("wr_evict", 1'b1, 32'h0000_2120, 32'hdead_beef, 4'hf, 1'b0, '0);
    stim[7] = make_entry("rd_evict", 1'b0, 32'h0000_2120, '0, 4'h0, 1'b1, 32'hdead_beef);
    stim[8] = make_entry("rd_refetch", 1'b0, 32'h0000_0120, '0, 4'h0, 1'b1, 32'ha5a5_1234);
    stim[9] = make_entry("rd_refetch_b", 1'b0, 32'h0000_0124, '0, 4'h0, 1'b1, 32'h4411_2211);
    stim[10] = make_entry("rd_tag1_back", 1'b0, 32'h0000_2120, '0, 4'h0, 1'b1, 32'hdead_beef);
    lfsr = 32'h7e46_6fe0;
    for (int i = 0; i < rand_count; i++) begin
      bits = draw_bits(1);
      wr = bits[0];
      bits = draw_bits(1);
      addr = {18'b0, bits[0], 13'b0};
      bits = draw_bits(2);
      addr[12:5] = pick_line(bits[1:0]);
      bits = draw_bits(3);
      addr[4:2] = bits[2:0];
      data = '0;
      mask = 4'h0;
      if (wr) begin
        // mostly whole words, sometimes a few lanes
        bits = draw_bits(2);
        mask = 4'hf;
        if (bits[1:0] == 2'b11) begin
          bits = draw_bits(4);
          mask = (bits[3:0] == 4'h0) ? 4'h1 : bits[3:0];
        end
        data = draw_bits(32);
      end
      stim[fixed_count + i] = make_entry({"rand_", 8'h30 + 8'(i / 10), 8'h30 + 8'(i % 10)},
                                         wr, addr, data, mask, 1'b0, '0);
    end
  endtask

  task automatic apply_entry(input stim_t s);
    @(negedge clk);
    enable = 1'b1;
    address = s.addr;
    data_in = s.write ? s.data : 32'h0;
    write_enable = s.write ? s.mask : 4'h0;
    test_name = s.name;
    exp_valid = s.has_exp;
    exp_data = s.exp_data;
    // taken on the first rising edge with busy low
    do begin
      @(posedge clk);
    end while (busy);
  endtask

  initial begin
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    data_in = '0;
    write_enable = 4'h0;
    test_name = "reset";
    check_idle = 1'b0;
    exp_valid = 1'b0;
    exp_data = '0;
    build_table();
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    // tag sweep holds busy until every line is invalid
    do begin
      @(posedge clk);
    end while (busy);
    @(negedge clk);
    test_name = "idle_after_clear";
    check_idle = 1'b1;
    @(negedge clk);
    check_idle = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      apply_entry(stim[i]);
    end
    @(negedge clk);
    enable = 1'b0;
    write_enable = 4'h0;
    @(negedge clk);
    $display("tests run %0d, passed %0d, failed %0d",
             pass_count + fail_count, pass_count, fail_count);
    if (fail_count == 0 && pass_count == num_tests) begin
      $display("Test completed successfully");
    end else begin
      if (pass_count + fail_count != num_tests) begin
        $display("expected %0d test results but saw %0d", num_tests, pass_count + fail_count);
      end
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(limit_cycles * clk_period);
    $display("watchdog: run did not finish within %0d cycles, stuck in %0s",
             limit_cycles, test_name);
    $display("Test failed");
    $finish;
  end

endmodule

// File: bench/cache_checker.sv
//########################################
// checker for the cache subsystem testbench
// watches the processor port, keeps a byte-lane reference
// memory and compares every completed read against it
// one line per finished test, counts go back to the top
//########################################
`timescale 1ns/10ps

module cache_checker (
  input  logic clk,
  input  logic rst_n,
  input  logic enable,
  input  logic [31:0] address,
  input  logic [31:0] data_in,
  input  logic [3:0] write_enable,
  input  logic [31:0] data_out,
  input  logic data_out_ready,
  input  logic busy,
  input  logic [127:0] test_name,
  input  logic check_idle,
  input  logic exp_valid,
  input  logic [31:0] exp_data,
  output int pass_count,
  output int fail_count
);

  // 16 KB of burst RAM as 32-bit words
  localparam int unsigned word_ix_bits = 12;

  logic [31:0] ref_mem [2**word_ix_bits];
  logic [3:0] ref_known [2**word_ix_bits];
  logic test_bad;
  int passes;
  int fails;

  assign pass_count = passes;
  assign fail_count = fails;

  initial begin
    passes = 0;
    fails = 0;
    test_bad = 1'b0;
    for (int i = 0; i < 2**word_ix_bits; i++) begin
      ref_mem[i] = '0;
      ref_known[i] = '0;
    end
  end

  function automatic logic [31:0] lane_mask(input logic [3:0] lanes);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) begin
      m[i*8 +: 8] = {8{lanes[i]}};
    end
    return m;
  endfunction

  task automatic finish_test(input logic bad);
    if (bad) begin
      fails++;
      $display("FAIL  %0s", test_name);
    end else begin
      passes++;
      $display("pass  %0s", test_name);
    end
    test_bad = 1'b0;
  endtask

  always @(posedge clk) begin
    logic [word_ix_bits-1:0] ix;
    logic [31:0] keep;
    logic [31:0] expected;
    logic bad;
    ix = address[word_ix_bits+1:2];
    if (rst_n) begin
      if (enable && write_enable != 4'h0 && data_out_ready) begin
        $display("data_out_ready went high during a write in %0s", test_name);
        test_bad = 1'b1;
      end
      if (enable && address[31:word_ix_bits+2] != '0) begin
        $display("address %h in %0s lies outside the burst RAM", address, test_name);
        test_bad = 1'b1;
      end
      if (check_idle) begin
        bad = busy || data_out_ready;
        if (bad) begin
          $display("CHECK FAILED %0s expected busy=0 ready=0 actual busy=%b ready=%b",
                   test_name, busy, data_out_ready);
        end
        finish_test(bad);
      end
      // a request is taken on an edge with enable high and busy low
      if (enable && !busy) begin
        if (write_enable != 4'h0) begin
          keep = lane_mask(write_enable);
          ref_mem[ix] = (ref_mem[ix] & ~keep) | (data_in & keep);
          ref_known[ix] = ref_known[ix] | write_enable;
          finish_test(test_bad);
        end else begin
          // lanes never written are unknown in the burst RAM
          keep = lane_mask(ref_known[ix]);
          expected = exp_valid ? exp_data : ref_mem[ix];
          bad = ((data_out ^ ref_mem[ix]) & keep) != 0;
          bad = bad || (exp_valid && data_out != exp_data);
          if (!data_out_ready) begin
            $display("read in %0s completed without data_out_ready", test_name);
            test_bad = 1'b1;
          end
          if (bad) begin
            $display("CHECK FAILED %0s expected %h actual %h", test_name, expected, data_out);
          end
          finish_test(bad || test_bad);
        end
      end
    end
  end

endmodule

// File: logic/cache_subsystem.sv
//########################################
// cache joined to the burst RAM model
// processor side ports only, no added latency
//########################################
`timescale 1ns/10ps

module cache_subsystem
  import cache_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic enable,
  input  logic [31:0] address,
  input  logic [31:0] data_in,
  input  logic [3:0] write_enable,
  output logic [31:0] data_out,
  output logic data_out_ready,
  output logic busy
);

  // burst link between the two
  br_cmd_t br_cmd;
  br_rsp_t br_rsp;

  cache u_cache (
    .clk,
    .rst_n,
    .enable,
    .address,
    .data_in,
    .write_enable,
    .data_out,
    .data_out_ready,
    .busy,
    .br_cmd,
    .br_rsp
  );

  burst_ram u_burst_ram (
    .clk,
    .rst_n,
    .br_cmd,
    .br_rsp
  );

endmodule

// File: logic/burst_ram.sv
//########################################
// on-chip stand-in for the PSRAM controller
// one command starts a four beat burst of 64-bit words
// reads return after a fixed latency, writes cannot stall
// 16 KB of store, only the low address bits are decoded
//########################################
`timescale 1ns/10ps
`include "cache_consts.svh"

module burst_ram
  import cache_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  br_cmd_t br_cmd,
  output br_rsp_t br_rsp
);

  localparam int unsigned beat_ix_bits = $clog2(`CACHE_BURST_BEATS);
  // 2048 beats of 8 bytes
  localparam int unsigned store_bits = 11;
  localparam int unsigned base_bits = store_bits - beat_ix_bits;
  localparam int unsigned lat_bits = `CACHE_BURST_LATENCY - 2;

  cache_addr_t cmd_addr;
  logic [`CACHE_TAG_BITS+`CACHE_LINE_IX_BITS-1:0] cmd_line;
  logic [base_bits-1:0] base_q;
  logic [beat_ix_bits-1:0] beat_q;
  logic [7:0] mask_q;
  logic [63:0] wr_data_q;
  logic wr_active;
  logic rd_active;
  logic [lat_bits-1:0] lat_sr;
  logic rd_valid_q;
  logic [store_bits-1:0] ram_addr;
  logic [3:0] we_lo;
  logic [3:0] we_hi;
  logic [31:0] rd_lo;
  logic [31:0] rd_hi;

  assign cmd_addr = cache_addr_t'(32'(br_cmd.addr));
  assign cmd_line = {cmd_addr.tag, cmd_addr.line};

  assign ram_addr = {base_q, beat_q};
  assign we_lo = wr_active ? ~mask_q[3:0] : 4'b0;
  assign we_hi = wr_active ? ~mask_q[7:4] : 4'b0;
  assign br_rsp = '{rd_data: {rd_hi, rd_lo}, rd_valid: rd_valid_q};

  bram #(.address_bits(store_bits)) u_lo (
    .clk,
    .write_enable(we_lo),
    .address(ram_addr),
    .data_in(wr_data_q[31:0]),
    .data_out(rd_lo)
  );

  bram #(.address_bits(store_bits)) u_hi (
    .clk,
    .write_enable(we_hi),
    .address(ram_addr),
    .data_in(wr_data_q[63:32]),
    .data_out(rd_hi)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_active <= 1'b0;
      rd_active <= 1'b0;
      lat_sr <= '0;
      rd_valid_q <= 1'b0;
      beat_q <= '0;
    end else begin
      // read commands ripple down until the RAM reads start
      lat_sr <= {lat_sr[lat_bits-2:0], br_cmd.valid && !br_cmd.write};
      // registered RAM output is one cycle behind the read
      rd_valid_q <= rd_active;
      if (wr_active || rd_active) begin
        beat_q <= beat_q + 1'b1;
        if (beat_q == beat_ix_bits'(`CACHE_BURST_BEATS - 1)) begin
          wr_active <= 1'b0;
          rd_active <= 1'b0;
        end
      end
      if (lat_sr[lat_bits-1]) begin
        rd_active <= 1'b1;
      end
      if (br_cmd.valid) begin
        beat_q <= '0;
        wr_active <= br_cmd.write;
      end
    end
  end

  // write beats land one cycle after they appear on the bus
  always_ff @(posedge clk) begin
    wr_data_q <= br_cmd.wr_data;
    if (br_cmd.valid) begin
      base_q <= cmd_line[base_bits-1:0];
      mask_q <= br_cmd.data_mask;
    end
  end

  // the cache spaces commands so a burst is never cut short
  assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd.valid |-> !(wr_active || rd_active || lat_sr != '0));

endmodule

// File: logic/cache.sv
//########################################
// direct mapped write-back data cache
// processor side uses enable / busy, address held while busy
// burst side talks to a 64-bit RAM in four beat bursts
// a tag sweep after reset keeps busy high until all lines are invalid
//########################################
`timescale 1ns/10ps
`include "cache_consts.svh"

module cache
  import cache_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic enable,
  input  logic [31:0] address,
  input  logic [31:0] data_in,
  input  logic [3:0] write_enable,
  output logic [31:0] data_out,
  output logic data_out_ready,
  output logic busy,
  output br_cmd_t br_cmd,
  input  br_rsp_t br_rsp
);

  localparam int unsigned col_count = 2 ** `CACHE_COL_IX_BITS;
  localparam int unsigned cnt_bits = $clog2(`CACHE_CMD_INTERVAL + 1);

  typedef enum logic [3:0] {
    Clear, Idle,
    WriteBeat1, WriteBeat2, WriteBeat3, WriteWait,
    ReadWait, ReadBeat1, ReadBeat2, ReadBeat3, ReadFinish
  } state_e;

  cache_addr_t addr;
  cache_addr_t victim;
  cache_addr_t fetch;
  state_e state;
  logic [`CACHE_LINE_IX_BITS-1:0] clear_ix;
  logic [`CACHE_LINE_IX_BITS-1:0] ram_line;
  logic [`CACHE_LINE_IX_BITS-1:0] rd_line_q;
  logic fresh_q;
  logic lookup_ok;
  logic hit;
  logic proc_write;
  logic fill_write;
  logic [1:0] fill_beat;
  logic [cnt_bits-1:0] cmd_cnt;
  logic [cnt_bits-1:0] cmd_gap;
  tag_word_u tag_rd;
  tag_word_u tag_wr;
  logic tag_we;
  logic [31:0] col_out [col_count];
  logic [31:0] col_din [col_count];
  logic [3:0] col_we [col_count];
  logic cmd_write_q;
  logic cmd_valid_q;
  logic [`CACHE_RAM_ADDR_BITS-1:0] cmd_addr_q;
  logic [63:0] wr_data_q;

  assign addr = address;

  // the sweep owns the RAM address until every tag is cleared
  assign ram_line = (state == Clear) ? clear_ix : addr.line;

  // RAM outputs belong to this line and were not just overwritten
  assign lookup_ok = fresh_q && rd_line_q == addr.line;
  assign hit = lookup_ok && tag_rd.entry.valid && tag_rd.entry.tag == addr.tag;

  assign busy = (enable && !hit) || cmd_cnt != 0 || state == Clear;
  assign data_out = col_out[addr.column];
  assign data_out_ready = enable && write_enable == 4'b0 && hit;
  assign proc_write = enable && write_enable != 4'b0 && !busy && state == Idle;

  assign fill_write = br_rsp.rd_valid &&
                      state inside {ReadWait, ReadBeat1, ReadBeat2, ReadBeat3};

  assign br_cmd = '{write: cmd_write_q, valid: cmd_valid_q, addr: cmd_addr_q,
                    wr_data: wr_data_q, data_mask: 8'h00};

  // line start addresses for eviction and fetch
  always_comb begin
    victim = '0;
    victim.tag = tag_rd.entry.tag;
    victim.line = addr.line;
    fetch = '0;
    fetch.tag = addr.tag;
    fetch.line = addr.line;
  end

  always_comb begin
    case (state)
      ReadBeat1: fill_beat = 2'd1;
      ReadBeat2: fill_beat = 2'd2;
      ReadBeat3: fill_beat = 2'd3;
      default:   fill_beat = 2'd0;
    endcase
  end

  // write port steering for tag and columns
  always_comb begin
    tag_we = 1'b0;
    tag_wr.raw = '0;
    for (int i = 0; i < col_count; i++) begin
      col_we[i] = 4'b0;
      col_din[i] = data_in;
    end
    if (state == Clear) begin
      tag_we = 1'b1;
    end else if (state == ReadFinish) begin
      // fetched line lands clean
      tag_we = 1'b1;
      tag_wr.entry.valid = 1'b1;
      tag_wr.entry.tag = addr.tag;
    end else if (fill_write) begin
      // each beat fills two neighbouring columns
      col_we[{fill_beat, 1'b0}] = 4'hf;
      col_we[{fill_beat, 1'b1}] = 4'hf;
      col_din[{fill_beat, 1'b0}] = br_rsp.rd_data[31:0];
      col_din[{fill_beat, 1'b1}] = br_rsp.rd_data[63:32];
    end else if (proc_write) begin
      tag_we = 1'b1;
      tag_wr.entry.dirty = 1'b1;
      tag_wr.entry.valid = 1'b1;
      tag_wr.entry.tag = addr.tag;
      col_we[addr.column] = write_enable;
    end
  end

  bram #(
    .address_bits(`CACHE_LINE_IX_BITS)
  ) u_tag (
    .clk,
    .write_enable({4{tag_we}}),
    .address(ram_line),
    .data_in(tag_wr.raw),
    .data_out(tag_rd.raw)
  );

  for (genvar i = 0; i < col_count; i++) begin : g_col
    bram #(
      .address_bits(`CACHE_LINE_IX_BITS)
    ) u_col (
      .clk,
      .write_enable(col_we[i]),
      .address(ram_line),
      .data_in(col_din[i]),
      .data_out(col_out[i])
    );
  end

  always_ff @(posedge clk) begin
    rd_line_q <= ram_line;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= Clear;
      clear_ix <= '0;
      cmd_cnt <= '0;
      cmd_valid_q <= 1'b0;
      fresh_q <= 1'b0;
    end else begin
      cmd_valid_q <= 1'b0;
      fresh_q <= !tag_we;
      if (cmd_cnt != 0) begin
        cmd_cnt <= cmd_cnt - 1'b1;
      end
      case (state)
        Clear: begin
          clear_ix <= clear_ix + 1'b1;
          if (&clear_ix) begin
            state <= Idle;
          end
        end
        Idle: begin
          if (enable && lookup_ok && !hit && cmd_cnt == 0) begin
            cmd_valid_q <= 1'b1;
            cmd_cnt <= cnt_bits'(`CACHE_CMD_INTERVAL);
            if (tag_rd.entry.valid && tag_rd.entry.dirty) begin
              // victim goes out first, beat 0 rides with the command
              cmd_write_q <= 1'b1;
              cmd_addr_q <= victim[`CACHE_RAM_ADDR_BITS-1:0];
              wr_data_q <= {col_out[1], col_out[0]};
              state <= WriteBeat1;
            end else begin
              cmd_write_q <= 1'b0;
              cmd_addr_q <= fetch[`CACHE_RAM_ADDR_BITS-1:0];
              state <= ReadWait;
            end
          end
        end
        WriteBeat1: begin
          wr_data_q <= {col_out[3], col_out[2]};
          state <= WriteBeat2;
        end
        WriteBeat2: begin
          wr_data_q <= {col_out[5], col_out[4]};
          state <= WriteBeat3;
        end
        WriteBeat3: begin
          wr_data_q <= {col_out[7], col_out[6]};
          state <= WriteWait;
        end
        WriteWait: begin
          // fetch only once the interval since the write burst is over
          if (cmd_cnt == 0) begin
            cmd_valid_q <= 1'b1;
            cmd_write_q <= 1'b0;
            cmd_addr_q <= fetch[`CACHE_RAM_ADDR_BITS-1:0];
            cmd_cnt <= cnt_bits'(`CACHE_CMD_INTERVAL);
            state <= ReadWait;
          end
        end
        ReadWait: begin
          if (br_rsp.rd_valid) begin
            state <= ReadBeat1;
          end
        end
        ReadBeat1: state <= ReadBeat2;
        ReadBeat2: state <= ReadBeat3;
        ReadBeat3: state <= ReadFinish;
        ReadFinish: state <= Idle;
        default: state <= Idle;
      endcase
    end
  end

  // cycles since the last burst command, saturating
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_gap <= '1;
    end else if (br_cmd.valid) begin
      cmd_gap <= '0;
    end else if (cmd_gap != '1) begin
      cmd_gap <= cmd_gap + 1'b1;
    end
  end

  // burst commands keep the RAM's minimum spacing
  assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd.valid |-> cmd_gap >= cnt_bits'(`CACHE_CMD_INTERVAL));

  // read beats only arrive while a fill is expected
  assert property (@(posedge clk) disable iff (!rst_n)
    br_rsp.rd_valid |-> state inside {ReadWait, ReadBeat1, ReadBeat2, ReadBeat3});

  // requester holds its address while a miss is served
  assert property (@(posedge clk) disable iff (!rst_n)
    (enable && busy && !(state inside {Clear, Idle})) |=> $stable(address));

endmodule

// File: logic/bram.sv
//########################################
// single port block RAM, 32 bits wide
// byte lane write enables, registered read-first output
// depth set by address_bits
//########################################
`timescale 1ns/10ps

module bram #(
  parameter int unsigned address_bits = 8
) (
  input  logic clk,
  input  logic [3:0] write_enable,
  input  logic [address_bits-1:0] address,
  input  logic [31:0] data_in,
  output logic [31:0] data_out
);

  logic [31:0] mem [2**address_bits];

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (write_enable[i]) begin
        mem[address][i*8 +: 8] <= data_in[i*8 +: 8];
      end
    end
    // old contents come out on a write cycle
    data_out <= mem[address];
  end

endmodule

// File: logic/cache_pkg.sv
//########################################
// types shared by the cache and the burst RAM model
// address split, tag entry and the burst command bundles
// import with cache_pkg::* in the module header
//########################################
`include "cache_consts.svh"

package cache_pkg;

  // processor byte address as the cache sees it
  typedef struct packed {
    logic [31-`CACHE_RAM_ADDR_BITS:0] upper;
    logic [`CACHE_TAG_BITS-1:0] tag;
    logic [`CACHE_LINE_IX_BITS-1:0] line;
    logic [`CACHE_COL_IX_BITS-1:0] column;
    logic [1:0] zero;
  } cache_addr_t;

  // one word of the tag RAM
  typedef struct packed {
    logic dirty;
    logic valid;
    logic [29-`CACHE_TAG_BITS:0] pad;
    logic [`CACHE_TAG_BITS-1:0] tag;
  } tag_entry_t;

  // tag RAM stores plain words, the cache reads them as entries
  typedef union packed {
    logic [31:0] raw;
    tag_entry_t entry;
  } tag_word_u;

  // cache to burst RAM
  typedef struct packed {
    logic write;
    logic valid;
    logic [`CACHE_RAM_ADDR_BITS-1:0] addr;
    logic [63:0] wr_data;
    logic [7:0] data_mask;
  } br_cmd_t;

  // burst RAM to cache
  typedef struct packed {
    logic [63:0] rd_data;
    logic rd_valid;
  } br_rsp_t;

endpackage

// File: logic/cache_consts.svh
//########################################
// geometry and timing constants shared by the cache,
// the burst RAM model and the testbench
// include wherever a width or a burst timing value is needed
//########################################
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// 256 lines
`define CACHE_LINE_IX_BITS 8

// 8 words of 4 bytes per line
`define CACHE_COL_IX_BITS 3

// byte address width on the burst side
`define CACHE_RAM_ADDR_BITS 21

// what is left after line, column and the two byte bits
`define CACHE_TAG_BITS (`CACHE_RAM_ADDR_BITS - `CACHE_LINE_IX_BITS - `CACHE_COL_IX_BITS - 2)

// cycles a new burst command must wait after the last one
`define CACHE_CMD_INTERVAL 13

// read command to first beat in the burst RAM model
`define CACHE_BURST_LATENCY 6
`define CACHE_BURST_BEATS 4

`endif
